// ==== Makefile ====
# Verilator build of the JTAG debug transport testbench

TOP := tb_dtm

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f \
		-Mdir obj_dir -o V$(TOP)

# a $fatal in the run gives a nonzero exit status
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== build.f ====
design/jtag_pkg.sv
design/dtm_pkg.sv
design/tap_ctrl.sv
design/dr_shift_reg.sv
design/data_regs.sv
design/scan_select.sv
design/dmi_port.sv
design/dtm_top.sv
verif/tck_gen.sv
verif/tb_dtm.sv

// ==== design/data_regs.sv ====
/*
 * Data registers of the debug transport: IDCODE, DTMCS, DMI and BYPASS.
 * Gates the TAP DR controls by the current instruction, builds the
 * capture words, and muxes the selected register onto dr_tdo.
 * DMI updates leave as dmi_update plus fields; DTMCS can raise a hard reset.
 */
module data_regs #(
    parameter logic [31:0] IDCODE = dtm_pkg::IDCODE_DEFAULT
) (
    input  logic                   tck,
    input  logic                   resetn,
    input  logic                   tdi,
    input  jtag_pkg::inst_t        inst,
    input  logic                   capture_dr,
    input  logic                   shift_dr,
    input  logic                   update_dr,
    input  logic [31:0]            dmi_rdata_hold,
    output logic                   dr_tdo,
    output logic                   dmi_update,
    output logic [dtm_pkg::ABITS-1:0] dmi_addr,
    output logic [31:0]            dmi_wdata,
    output dtm_pkg::dmi_op_t       dmi_op,
    output logic                   dtm_hard_reset
);
    import jtag_pkg::*;
    import dtm_pkg::*;

    logic        sel_idcode, sel_dtmcs, sel_dmi;
    logic [31:0] idcode_sreg;
    logic        bypass_ff;
    logic        dtmcs_tdo, dmi_tdo;
    logic        dtmcs_upd_d;
    dtmcs_t      dtmcs_cap, dtmcs_val;
    dmi_t        dmi_cap, dmi_val;

    assign sel_idcode = (inst == INST_IDCODE);
    assign sel_dtmcs  = (inst == INST_DTMCS);
    assign sel_dmi    = (inst == INST_DMI);

    ////////////////////////////////////////////////////////////////////////////
    // idcode and bypass
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge tck) begin
        if (capture_dr && sel_idcode) begin
            idcode_sreg <= IDCODE;
        end else if (shift_dr && sel_idcode) begin
            idcode_sreg <= {tdi, idcode_sreg[31:1]};
        end
    end

    // captures 0, one bit of delay through the chain
    always_ff @(posedge tck or negedge resetn) begin
        if (!resetn) begin
            bypass_ff <= 1'b0;
        end else if (capture_dr) begin
            bypass_ff <= 1'b0;
        end else if (shift_dr) begin
            bypass_ff <= tdi;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // dtmcs
    ////////////////////////////////////////////////////////////////////////////
    // no busy tracking, so dmistat and idle stay 0
    always_comb begin
        dtmcs_cap         = '0;
        dtmcs_cap.version = DTM_VERSION;
        dtmcs_cap.abits   = 6'(ABITS);
    end

    dr_shift_reg #(.payload_t(dtmcs_t)) u_dtmcs (
        .tck           (tck),
        .resetn        (resetn),
        .tdi           (tdi),
        .capture       (capture_dr && sel_dtmcs),
        .shift         (shift_dr && sel_dtmcs),
        .update        (update_dr && sel_dtmcs),
        .capture_value (dtmcs_cap),
        .sout          (dtmcs_tdo),
        .value         (dtmcs_val)
    );

    // value is fresh the cycle after update-dr
    always_ff @(posedge tck or negedge resetn) begin
        if (!resetn) begin
            dtmcs_upd_d <= 1'b0;
        end else begin
            dtmcs_upd_d <= update_dr && sel_dtmcs;
        end
    end

    assign dtm_hard_reset = dtmcs_upd_d && dtmcs_val.dtmhardreset;

    ////////////////////////////////////////////////////////////////////////////
    // dmi
    ////////////////////////////////////////////////////////////////////////////
    // op 0 on capture reports success
    assign dmi_cap = '{addr: dmi_val.addr, data: dmi_rdata_hold, op: DMI_NOP};

    dr_shift_reg #(.payload_t(dmi_t)) u_dmi (
        .tck           (tck),
        .resetn        (resetn),
        .tdi           (tdi),
        .capture       (capture_dr && sel_dmi),
        .shift         (shift_dr && sel_dmi),
        .update        (update_dr && sel_dmi),
        .capture_value (dmi_cap),
        .sout          (dmi_tdo),
        .value         (dmi_val)
    );

    assign dmi_update = update_dr && sel_dmi;
    assign dmi_addr   = dmi_val.addr;
    assign dmi_wdata  = dmi_val.data;
    assign dmi_op     = dmi_val.op;

    // unknown codes, 00 and 1F included, fall to bypass
    always_comb begin
        case (inst)
            INST_IDCODE: dr_tdo = idcode_sreg[0];
            INST_DTMCS:  dr_tdo = dtmcs_tdo;
            INST_DMI:    dr_tdo = dmi_tdo;
            default:     dr_tdo = bypass_ff;
        endcase
    end

    // ir only changes in update-ir, never under a dmi update
    a_dmi_inst: assert property (@(posedge tck) disable iff (!resetn)
        dmi_update |-> (inst == INST_DMI) && $stable(inst));

endmodule

// ==== design/dmi_port.sv ====
/*
 * DMI side of the transport.
 * Turns each DMI update into a one-cycle dmi_req with its fields held
 * until the next request, and keeps the debug module's read data for the
 * next DMI capture. A DTM hard reset drops the held read data.
 */
module dmi_port (
    input  logic                      tck,
    input  logic                      resetn,
    input  logic                      dmi_update,
    input  logic [dtm_pkg::ABITS-1:0] dmi_addr,
    input  logic [31:0]               dmi_wdata,
    input  dtm_pkg::dmi_op_t          dmi_op,
    input  logic                      dtm_hard_reset,
    input  logic [31:0]               dmi_rdata,
    output logic                      dmi_req,
    output logic [dtm_pkg::ABITS-1:0] dmi_req_addr,
    output logic [31:0]               dmi_req_data,
    output dtm_pkg::dmi_op_t          dmi_req_op,
    output logic [31:0]               dmi_rdata_hold
);
    import dtm_pkg::*;

    logic             req_d;
    logic [ABITS-1:0] addr_q;
    logic [31:0]      data_q;
    dmi_op_t          op_q;

    // update-dr is one cycle, so is the request
    always_ff @(posedge tck or negedge resetn) begin
        if (!resetn) begin
            dmi_req <= 1'b0;
            req_d   <= 1'b0;
            addr_q  <= '0;
            data_q  <= '0;
            op_q    <= DMI_NOP;
        end else begin
            dmi_req <= dmi_update;
            req_d   <= dmi_req;
            // fields settle upstream with the pulse, keep them afterwards
            if (dmi_req) begin
                addr_q <= dmi_addr;
                data_q <= dmi_wdata;
                op_q   <= dmi_op;
            end
        end
    end

    // live during the pulse, held copy afterwards
    assign dmi_req_addr = dmi_req ? dmi_addr  : addr_q;
    assign dmi_req_data = dmi_req ? dmi_wdata : data_q;
    assign dmi_req_op   = dmi_req ? dmi_op    : op_q;

    // sample in the request cycle and once more for a registered responder
    always_ff @(posedge tck or negedge resetn) begin
        if (!resetn) begin
            dmi_rdata_hold <= '0;
        end else if (dtm_hard_reset) begin
            dmi_rdata_hold <= '0;
        end else if (dmi_req || req_d) begin
            dmi_rdata_hold <= dmi_rdata;
        end
    end

    a_req_pulse: assert property (@(posedge tck) disable iff (!resetn)
        dmi_req |=> !dmi_req);

endmodule

// ==== design/dr_shift_reg.sv ====
/*
 * Generic capture/shift/update data register.
 * The shift stage loads capture_value on capture, shifts right on shift
 * with tdi entering at the msb, and copies into value on update.
 * payload_t sets both the width and the view of the parallel ports.
 */
module dr_shift_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     tck,
    input  logic     resetn,
    input  logic     tdi,
    input  logic     capture,
    input  logic     shift,
    input  logic     update,
    input  payload_t capture_value,
    output logic     sout,
    output payload_t value
);
    localparam int WIDTH = $bits(payload_t);

    logic [WIDTH-1:0] sreg;

    // shift stage, lsb goes out first
    always_ff @(posedge tck) begin
        if (capture) begin
            sreg <= capture_value;
        end else if (shift) begin
            sreg <= {tdi, sreg[WIDTH-1:1]};
        end
    end

    assign sout = sreg[0];

    // update stage
    // holds the last scanned word until the next update
    always_ff @(posedge tck or negedge resetn) begin
        if (!resetn) begin
            value <= payload_t'('0);
        end else if (update) begin
            value <= payload_t'(sreg);
        end
    end

endmodule

// ==== design/dtm_pkg.sv ====
/*
 * Debug-transport register layouts: DTMCS fields, the DMI scan word and
 * the widths and constants around them. The default IDCODE lives here and
 * seeds the top-level parameter. Import with dtm_pkg::* in module bodies.
 */
package dtm_pkg;

    // dmi address width, reported through dtmcs.abits
    localparam int ABITS     = 7;
    localparam int DMI_WIDTH = ABITS + 34;

    // request op on update; on capture 0 reads back as success
    typedef enum logic [1:0] {
        DMI_NOP   = 2'd0,
        DMI_READ  = 2'd1,
        DMI_WRITE = 2'd2
    } dmi_op_t;

    // scan order lsb first: op, then data, then address
    typedef struct packed {
        logic [ABITS-1:0] addr;
        logic [31:0]      data;
        dmi_op_t          op;
    } dmi_t;

    typedef struct packed {
        logic [13:0] reserved1;
        logic        dtmhardreset;
        logic        dmireset;
        logic        reserved0;
        logic [2:0]  idle;
        logic [1:0]  dmistat;
        logic [5:0]  abits;
        logic [3:0]  version;
    } dtmcs_t;

    // debug spec 0.13 / 1.0 transport
    localparam logic [3:0] DTM_VERSION = 4'd1;

    localparam logic [31:0] IDCODE_DEFAULT = 32'h1002AC05;

endpackage

// ==== design/dtm_top.sv ====
/*
 * Top level of the JTAG debug transport module.
 * Connects the TAP controller, IR and scan-out stage, data registers and
 * the DMI port. IDCODE is set here and handed to the data registers.
 */
module dtm_top #(
    parameter logic [31:0] IDCODE = dtm_pkg::IDCODE_DEFAULT
) (
    input  logic                      tck,
    input  logic                      resetn,
    input  logic                      tms,
    input  logic                      tdi,
    output logic                      tdo,
    output logic                      tdo_en,
    output logic                      dmi_req,
    output logic [dtm_pkg::ABITS-1:0] dmi_req_addr,
    output logic [31:0]               dmi_req_data,
    output dtm_pkg::dmi_op_t          dmi_req_op,
    input  logic [31:0]               dmi_rdata
);
    import jtag_pkg::*;
    import dtm_pkg::*;

    logic             capture_dr, shift_dr, update_dr;
    logic             capture_ir, shift_ir, update_ir, test_logic_reset;
    inst_t            inst;
    logic             dr_tdo;
    logic             dmi_update, dtm_hard_reset;
    logic [ABITS-1:0] dmi_addr;
    logic [31:0]      dmi_wdata, dmi_rdata_hold;
    dmi_op_t          dmi_op;

    // tap state machine
    tap_ctrl u_tap (
        .tck, .resetn, .tms,
        .state (),
        .capture_dr, .shift_dr, .update_dr,
        .capture_ir, .shift_ir, .update_ir,
        .test_logic_reset
    );

    scan_select u_scan (
        .tck, .resetn, .tdi,
        .capture_ir, .shift_ir, .update_ir, .test_logic_reset,
        .shift_dr, .dr_tdo,
        .inst, .tdo, .tdo_en
    );

    data_regs #(.IDCODE(IDCODE)) u_regs (
        .tck, .resetn, .tdi, .inst,
        .capture_dr, .shift_dr, .update_dr, .dmi_rdata_hold,
        .dr_tdo, .dmi_update, .dmi_addr, .dmi_wdata, .dmi_op, .dtm_hard_reset
    );

    // dmi request side
    dmi_port u_dmi (
        .tck, .resetn,
        .dmi_update, .dmi_addr, .dmi_wdata, .dmi_op, .dtm_hard_reset, .dmi_rdata,
        .dmi_req, .dmi_req_addr, .dmi_req_data, .dmi_req_op, .dmi_rdata_hold
    );

endmodule

// ==== design/jtag_pkg.sv ====
/*
 * TAP-level definitions shared by the JTAG side of the debug transport.
 * Holds the sixteen-state TAP encoding and the 5-bit instruction codes.
 * Import with jtag_pkg::* inside a module body; use scoped names in headers.
 */
package jtag_pkg;

    // ieee 1149.1 style 4-bit state encoding
    typedef enum logic [3:0] {
        EXIT2_DR         = 4'h0,
        EXIT1_DR         = 4'h1,
        SHIFT_DR         = 4'h2,
        PAUSE_DR         = 4'h3,
        SELECT_IR        = 4'h4,
        UPDATE_DR        = 4'h5,
        CAPTURE_DR       = 4'h6,
        SELECT_DR        = 4'h7,
        EXIT2_IR         = 4'h8,
        EXIT1_IR         = 4'h9,
        SHIFT_IR         = 4'hA,
        PAUSE_IR         = 4'hB,
        RUN_TEST_IDLE    = 4'hC,
        UPDATE_IR        = 4'hD,
        CAPTURE_IR       = 4'hE,
        TEST_LOGIC_RESET = 4'hF
    } tap_state_t;

    localparam int IR_WIDTH = 5;

    typedef logic [IR_WIDTH-1:0] inst_t;

    // any code not listed here selects bypass
    localparam inst_t INST_IDCODE = 5'h01;
    localparam inst_t INST_DTMCS  = 5'h10;
    localparam inst_t INST_DMI    = 5'h11;
    localparam inst_t INST_BYPASS = 5'h1F;

endpackage

// ==== design/scan_select.sv ====
/*
 * Instruction register and scan-out stage.
 * Shifts the IR, applies it on Update-IR and falls back to IDCODE in
 * Test-Logic-Reset. Picks the IR or DR bit and drives tdo and tdo_en
 * from falling-edge flops so they settle half a cycle before sampling.
 */
module scan_select (
    input  logic            tck,
    input  logic            resetn,
    input  logic            tdi,
    input  logic            capture_ir,
    input  logic            shift_ir,
    input  logic            update_ir,
    input  logic            test_logic_reset,
    input  logic            shift_dr,
    input  logic            dr_tdo,
    output jtag_pkg::inst_t inst,
    output logic            tdo,
    output logic            tdo_en
);
    import jtag_pkg::*;

    logic [IR_WIDTH-1:0] ir_sreg;

    // ir shift stage, captures the fixed 01 pattern
    always_ff @(posedge tck) begin
        if (capture_ir) begin
            ir_sreg <= IR_WIDTH'(1);
        end else if (shift_ir) begin
            ir_sreg <= {tdi, ir_sreg[IR_WIDTH-1:1]};
        end
    end

    // current instruction
    always_ff @(posedge tck or negedge resetn) begin
        if (!resetn) begin
            inst <= INST_IDCODE;
        end else if (test_logic_reset) begin
            inst <= INST_IDCODE;
        end else if (update_ir) begin
            inst <= inst_t'(ir_sreg);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // falling-edge output
    ////////////////////////////////////////////////////////////////////////////
    // tdo parks at 0 outside shift states
    always_ff @(negedge tck or negedge resetn) begin
        if (!resetn) begin
            tdo    <= 1'b0;
            tdo_en <= 1'b0;
        end else begin
            tdo    <= shift_ir ? ir_sreg[0] : (shift_dr && dr_tdo);
            tdo_en <= shift_ir || shift_dr;
        end
    end

endmodule

// ==== design/tap_ctrl.sv ====
/*
 * Standard sixteen-state TAP controller.
 * Walks the state machine on tms and decodes the current state into
 * one-cycle capture, shift and update levels for the IR and DR paths.
 * Five tck cycles with tms high land in Test-Logic-Reset from anywhere.
 */
module tap_ctrl (
    input  logic                 tck,
    input  logic                 resetn,
    input  logic                 tms,
    output jtag_pkg::tap_state_t state,
    output logic                 capture_dr,
    output logic                 shift_dr,
    output logic                 update_dr,
    output logic                 capture_ir,
    output logic                 shift_ir,
    output logic                 update_ir,
    output logic                 test_logic_reset
);
    import jtag_pkg::*;

    tap_state_t next_state;

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (state)
            TEST_LOGIC_RESET: next_state = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    next_state = tms ? SELECT_DR : RUN_TEST_IDLE;
            SELECT_DR:        next_state = tms ? SELECT_IR : CAPTURE_DR;
            CAPTURE_DR:       next_state = tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         next_state = tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         next_state = tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         next_state = tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         next_state = tms ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:        next_state = tms ? SELECT_DR : RUN_TEST_IDLE;
            // ir branch mirrors dr, select-ir escapes to reset
            SELECT_IR:        next_state = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       next_state = tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         next_state = tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         next_state = tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         next_state = tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         next_state = tms ? UPDATE_IR : SHIFT_IR;
            UPDATE_IR:        next_state = tms ? SELECT_DR : RUN_TEST_IDLE;
            default:          next_state = TEST_LOGIC_RESET;
        endcase
    end

    always_ff @(posedge tck or negedge resetn) begin
        if (!resetn) begin
            state <= TEST_LOGIC_RESET;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // state decode
    ////////////////////////////////////////////////////////////////////////////
    // levels last exactly the cycle spent in the state
    assign capture_dr       = (state == CAPTURE_DR);
    assign shift_dr         = (state == SHIFT_DR);
    assign update_dr        = (state == UPDATE_DR);
    assign capture_ir       = (state == CAPTURE_IR);
    assign shift_ir         = (state == SHIFT_IR);
    assign update_ir        = (state == UPDATE_IR);
    assign test_logic_reset = (state == TEST_LOGIC_RESET);

    // downstream registers assume a single scan action per tck
    a_one_action: assert property (@(posedge tck) disable iff (!resetn)
        $onehot0({capture_dr, shift_dr, update_dr, capture_ir, shift_ir, update_ir}));

endmodule

// ==== verif/tb_dtm.sv ====
/*
 * Testbench for the JTAG debug transport top level.
 * Walks the TAP through IR and DR scans, models the debug module as a
 * simple responder and checks every scanned-out word and DMI request
 * against a reference. Stops on the first mismatch or at the cycle limit.
 */
module tb_dtm;
    import jtag_pkg::*;
    import dtm_pkg::*;

    localparam logic [31:0] DUT_IDCODE  = 32'h1E5CA0B3;
    localparam logic [31:0] SEED        = 32'h9e353375;
    // roughly 460 cycles of scans, so 4000 leaves wide slack
    localparam int          CYCLE_LIMIT = 4000;

    logic             tck;
    logic             resetn    = 1'b0;
    logic             tms       = 1'b1;
    logic             tdi       = 1'b0;
    logic [31:0]      dmi_rdata = '0;
    logic             tdo, tdo_en, dmi_req;
    logic [ABITS-1:0] dmi_req_addr;
    logic [31:0]      dmi_req_data;
    dmi_op_t          dmi_req_op;

    // model of what the dtm should hold for the next dmi capture
    logic [31:0]      hold_model    = '0;
    logic [ABITS-1:0] last_dmi_addr = '0;
    int               req_count     = 0;
    dmi_t             last_req;
    int               cycle_count   = 0;
    int               error_count   = 0;

    tck_gen #(.PERIOD(100)) u_tck (.tck(tck));

    dtm_top #(.IDCODE(DUT_IDCODE)) uut (
        .tck, .resetn, .tms, .tdi, .tdo, .tdo_en,
        .dmi_req, .dmi_req_addr, .dmi_req_data, .dmi_req_op, .dmi_rdata
    );

    ////////////////////////////////////////////////////////////////////////////
    // failure reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("FAIL @%0t: %s got %b expected %b",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("FAIL @%0t: %s got %h expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_dtmcs(input dtmcs_t got, input dtmcs_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("FAIL @%0t: %s got %h expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_dmi(input dmi_t got, input dmi_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("FAIL @%0t: %s got %h expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_op(input dmi_op_t got, input dmi_op_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("FAIL @%0t: %s got %0d expected %0d",
                                        $time, what, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////
    // word that a capture-dr loads for the given instruction
    function automatic logic [63:0] expected_capture(input inst_t code);
        dtmcs_t cs;
        dmi_t   dw;
        cs         = '0;
        cs.version = 4'd1;
        cs.abits   = 6'd7;
        dw.addr    = last_dmi_addr;
        dw.data    = hold_model;
        dw.op      = DMI_NOP;
        case (code)
            INST_IDCODE: expected_capture = 64'(DUT_IDCODE);
            INST_DTMCS:  expected_capture = 64'(cs);
            INST_DMI:    expected_capture = 64'(dw);
            // bypass flop captures 0
            default:     expected_capture = '0;
        endcase
    endfunction

    // debug module stand-in, new read data in the request cycle
    always @(posedge tck) begin
        if (resetn && dmi_req) begin
            req_count     <= req_count + 1;
            last_req.addr <= dmi_req_addr;
            last_req.data <= dmi_req_data;
            last_req.op   <= dmi_req_op;
            if (dmi_req_op == DMI_READ) begin
                // nonzero, so a cleared hold stands out
                dmi_rdata <= $urandom | 32'h1;
            end
        end
    end

    always @(posedge tck) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_with_failure($sformatf("timeout: run still going after %0d tck cycles",
                                        CYCLE_LIMIT));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tap drive
    ////////////////////////////////////////////////////////////////////////////
    // one tck cycle, called on a rising edge, returns tdo of that cycle
    task automatic clock_bit(input logic tms_v, input logic tdi_v, input logic en_exp,
                             output logic tdo_v);
        tms <= tms_v;
        tdi <= tdi_v;
        @(posedge tck);
        tdo_v = tdo;
        check_bit(tdo_en, en_exp, "tdo_en");
    endtask

    task automatic run_idle(input int cycles);
        logic bit_out;
        repeat (cycles) clock_bit(1'b0, 1'b0, 1'b0, bit_out);
    endtask

    // run-test/idle to run-test/idle through the ir column
    task automatic scan_ir(input inst_t code, output inst_t captured);
        logic bit_out;
        int   i;
        clock_bit(1'b1, 1'b0, 1'b0, bit_out);
        clock_bit(1'b1, 1'b0, 1'b0, bit_out);
        clock_bit(1'b0, 1'b0, 1'b0, bit_out);
        clock_bit(1'b0, 1'b0, 1'b0, bit_out);
        for (i = 0; i < IR_WIDTH; i++) begin
            clock_bit(i == IR_WIDTH - 1, code[i], 1'b1, bit_out);
            captured[i] = bit_out;
        end
        // exit1-ir, then update-ir
        clock_bit(1'b1, 1'b0, 1'b0, bit_out);
        clock_bit(1'b0, 1'b0, 1'b0, bit_out);
    endtask

    task automatic scan_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
        logic bit_out;
        int   i;
        dout = '0;
        clock_bit(1'b1, 1'b0, 1'b0, bit_out);
        clock_bit(1'b0, 1'b0, 1'b0, bit_out);
        clock_bit(1'b0, 1'b0, 1'b0, bit_out);
        for (i = 0; i < len; i++) begin
            clock_bit(i == len - 1, din[i], 1'b1, bit_out);
            dout[i] = bit_out;
        end
        clock_bit(1'b1, 1'b0, 1'b0, bit_out);
        clock_bit(1'b0, 1'b0, 1'b0, bit_out);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // scenarios
    ////////////////////////////////////////////////////////////////////////////
    task automatic bypass_test(input inst_t code);
        inst_t       ir_cap;
        logic [31:0] pattern;
        logic [63:0] dout;
        logic [63:0] exp_word;
        scan_ir(code, ir_cap);
        check_word(32'(ir_cap[1:0]), 32'h1, "ir capture low bits");
        pattern  = $urandom;
        exp_word = expected_capture(code);
        scan_dr(33, 64'(pattern), dout);
        check_bit(dout[0], exp_word[0], "bypass capture");
        check_word(dout[32:1], pattern, "bypass one-bit delay");
    endtask

    // dmi scan, then two idle cycles so any request has been seen
    task automatic dmi_scan(input dmi_t din, input string what);
        logic [63:0] dout;
        logic [63:0] exp_word;
        exp_word = expected_capture(INST_DMI);
        scan_dr(DMI_WIDTH, 64'(din), dout);
        check_dmi(dmi_t'(dout[DMI_WIDTH-1:0]), dmi_t'(exp_word[DMI_WIDTH-1:0]), what);
        last_dmi_addr = din.addr;
        run_idle(2);
        hold_model = dmi_rdata;
    endtask

    task automatic check_request(input dmi_t exp, input int reqs_before);
        dmi_t held;
        held.addr = dmi_req_addr;
        held.data = dmi_req_data;
        held.op   = dmi_req_op;
        check_word(32'(req_count - reqs_before), 32'd1, "dmi_req pulses");
        check_op(last_req.op, exp.op, "request op");
        check_dmi(last_req, exp, "request fields");
        check_dmi(held, exp, "held request fields");
    endtask

    initial begin : stimulus
        logic [63:0] dout;
        logic [63:0] exp_word;
        inst_t       ir_cap;
        dmi_t        dmi_in;
        dtmcs_t      cs_in;
        int          reqs_before;

        void'($urandom(SEED));
        repeat (8) @(posedge tck);
        resetn <= 1'b1;
        check_bit(tdo, 1'b0, "tdo after reset");
        check_bit(tdo_en, 1'b0, "tdo_en after reset");
        check_bit(dmi_req, 1'b0, "dmi_req after reset");
        // test-logic-reset to run-test/idle
        run_idle(1);

        // idcode is the default instruction
        exp_word = expected_capture(INST_IDCODE);
        scan_dr(32, '0, dout);
        check_word(dout[31:0], exp_word[31:0], "idcode after reset");

        bypass_test(INST_BYPASS);
        bypass_test(5'h00);

        scan_ir(INST_DTMCS, ir_cap);
        exp_word = expected_capture(INST_DTMCS);
        scan_dr(32, '0, dout);
        check_dtmcs(dtmcs_t'(dout[31:0]), dtmcs_t'(exp_word[31:0]), "dtmcs capture");

        // write, then read, then a nop that shows the read data
        scan_ir(INST_DMI, ir_cap);
        dmi_in.addr = ABITS'($urandom);
        dmi_in.data = $urandom;
        dmi_in.op   = DMI_WRITE;
        reqs_before = req_count;
        dmi_scan(dmi_in, "dmi capture before write");
        check_request(dmi_in, reqs_before);

        dmi_in.addr = ABITS'($urandom);
        dmi_in.data = $urandom;
        dmi_in.op   = DMI_READ;
        reqs_before = req_count;
        dmi_scan(dmi_in, "dmi capture before read");
        check_request(dmi_in, reqs_before);

        dmi_in.data = '0;
        dmi_in.op   = DMI_NOP;
        dmi_scan(dmi_in, "dmi read data");

        // hard reset drops the held read data
        scan_ir(INST_DTMCS, ir_cap);
        cs_in              = '0;
        cs_in.dtmhardreset = 1'b1;
        exp_word           = expected_capture(INST_DTMCS);
        scan_dr(32, 64'(cs_in), dout);
        check_dtmcs(dtmcs_t'(dout[31:0]), dtmcs_t'(exp_word[31:0]), "dtmcs before hard reset");
        run_idle(2);
        hold_model = '0;
        scan_ir(INST_DMI, ir_cap);
        dmi_scan(dmi_in, "dmi capture after hard reset");

        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_with_failure("run ended with failed checks");
        end
    end

endmodule

// ==== verif/tck_gen.sv ====
/*
 * Free-running test clock for the debug transport testbench.
 * Starts low at time 0 and toggles every half period.
 */
module tck_gen #(
    parameter int PERIOD = 100
) (
    output logic tck
);
    initial begin
        tck = 1'b0;
        forever begin
            #(PERIOD / 2) tck = ~tck;
        end
    end

endmodule
